//--- cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 64
`define LINE_BYTES 32

// address layout
// the set index sits between the line offset and the tag
`define ADR_W 32
`define LOBIT 5
`define HIBIT 10
`define TAGLOBIT 11

// memory bus
`define TID_W 8
`define NUM_RD_PORTS 2

`endif

//--- bus_pkg.sv
`default_nettype none
`include "cache_consts.svh"

package bus_pkg;

	// read channel request, a single cycle strobe
	typedef struct packed {
		logic cyc;
		logic [`TID_W-1:0] tid;
		logic [`ADR_W-1:0] adr;
	} rd_req_t;

	typedef struct packed {
		logic ack;
		logic [`LINE_BYTES*8-1:0] dat;
	} rd_resp_t;

	// write request level, held until wr_ack
	typedef struct packed {
		logic cyc;
		logic inv;
		logic [`ADR_W-1:0] adr;
		logic [`LINE_BYTES-1:0] sel;
		logic [`LINE_BYTES*8-1:0] dat;
	} wr_req_t;

	// line fill from the memory controller
	typedef struct packed {
		logic cyc;
		logic [`ADR_W-1:0] adr;
		logic [`LINE_BYTES*8-1:0] dat;
	} ld_req_t;

	typedef struct packed {
		logic cyc;
		logic [`TID_W-1:0] tid;
		logic [`ADR_W-1:0] adr;
	} miss_req_t;

endpackage

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none
`include "cache_consts.svh"

package cache_pkg;

	// one cached line with its tag and dirty flag
	typedef struct packed {
		logic [`ADR_W-`TAGLOBIT-1:0] tag;
		logic modified;
		logic [`LINE_BYTES*8-1:0] data;
	} cache_line_t;

	// way 0 holds the newest line of the set
	typedef cache_line_t [`CACHE_WAYS-1:0] cache_set_t;

	// one bit per way
	typedef logic [`CACHE_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

//--- cache_set_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module cache_set_ram (
	input wire logic wclk,
	input wire logic we,
	input wire logic [`HIBIT-`LOBIT:0] wr_idx,
	input wire cache_pkg::cache_set_t wr_set,
	input wire logic rd_en,
	input wire logic [`HIBIT-`LOBIT:0] rd_idx,
	output cache_pkg::cache_set_t rd_set
);

	// all four ways of a set live in one word
	cache_pkg::cache_set_t mem [0:`CACHE_SETS-1];

	always_ff @(posedge wclk) begin
		if (we)
			mem[wr_idx] <= wr_set;
	end

	// a read that meets a write to the same set returns the old word
	always_ff @(posedge wclk) begin
		if (rd_en)
			rd_set <= mem[rd_idx];
	end

endmodule

`default_nettype wire

//--- cache_read_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module cache_read_port (
	input wire logic wclk,
	input wire logic rst1,
	input wire bus_pkg::rd_req_t req,
	output bus_pkg::rd_resp_t resp,
	output logic rd_en,
	output logic [`HIBIT-`LOBIT:0] rd_idx,
	input wire cache_pkg::cache_set_t rd_set,
	input wire cache_pkg::way_mask_t valid,
	output logic miss_stb,
	output logic [`TID_W-1:0] miss_tid,
	output logic [`ADR_W-1:0] miss_adr,
	input wire logic issued
);

	logic pend;
	logic rd_vld;
	logic miss_sent;
	logic ack_r;
	logic hit_now;
	logic [`TID_W-1:0] tid_r;
	logic [`ADR_W-1:0] adr_r;
	logic [`LINE_BYTES*8-1:0] dat_r;
	logic [`LINE_BYTES*8-1:0] hit_dat;
	cache_pkg::way_mask_t vld_r;
	cache_pkg::way_mask_t hit;

	// ========================================
	// request capture
	// ========================================
	always_ff @(posedge wclk) begin
		if (req.cyc && !pend) begin
			tid_r <= req.tid;
			adr_r <= req.adr;
		end
	end

	// the set is re-read every cycle while the request is open
	assign rd_en = pend;
	assign rd_idx = adr_r[`HIBIT:`LOBIT];

	// valid bits are sampled on the same edge as the set word so both
	// describe the same moment
	always_ff @(posedge wclk) begin
		if (rd_en)
			vld_r <= valid;
	end

	// ========================================
	// tag compare and data select
	// ========================================
	always_comb begin
		hit_dat = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			hit[w] = vld_r[w] && (rd_set[w].tag == adr_r[`ADR_W-1:`TAGLOBIT]);
			if (hit[w])
				hit_dat = rd_set[w].data;
		end
	end

	assign hit_now = pend && rd_vld && (|hit);

	always_ff @(posedge wclk) begin
		if (rst1) begin
			pend <= 1'b0;
			rd_vld <= 1'b0;
			miss_sent <= 1'b0;
			ack_r <= 1'b0;
		end else begin
			ack_r <= hit_now;
			rd_vld <= rd_en && !hit_now;
			if (hit_now)
				pend <= 1'b0;
			else if (req.cyc)
				pend <= 1'b1;
			// one miss per request, rearmed once the line has hit
			if (hit_now)
				miss_sent <= 1'b0;
			else if (issued)
				miss_sent <= 1'b1;
		end
	end

	always_ff @(posedge wclk) begin
		if (hit_now)
			dat_r <= hit_dat;
	end

	assign resp = '{ack: ack_r, dat: dat_r};

	assign miss_stb = pend && rd_vld && !(|hit) && !miss_sent;
	assign miss_tid = tid_r;
	assign miss_adr = adr_r;

	a_ack_single: assert property (@(posedge wclk) disable iff (rst1) resp.ack |=> !resp.ack)
		else $error("read port ack high on two cycles in a row");

endmodule

`default_nettype wire

//--- cache_fill_update.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module cache_fill_update (
	input wire logic wclk,
	input wire logic rst1,
	input wire bus_pkg::ld_req_t ld,
	input wire bus_pkg::wr_req_t wr,
	output logic wr_ack,
	output logic sweeping,
	output logic ram_we,
	output logic [`HIBIT-`LOBIT:0] ram_idx,
	output cache_pkg::cache_set_t ram_wset,
	input wire cache_pkg::cache_set_t own_rd_set,
	output logic [`HIBIT-`LOBIT:0] own_rd_idx,
	input wire logic [`HIBIT-`LOBIT:0] port_idx [`NUM_RD_PORTS],
	output cache_pkg::way_mask_t port_valid [`NUM_RD_PORTS]
);

	cache_pkg::way_mask_t vbits [0:`CACHE_SETS-1];
	logic [`HIBIT-`LOBIT+1:0] swp_cnt;
	logic [`HIBIT-`LOBIT:0] swp_idx;

	logic ld_d1;
	logic ld_d2;
	logic [`ADR_W-1:0] ld_adr_r;
	logic [`LINE_BYTES*8-1:0] ld_dat_r;
	cache_pkg::cache_line_t ld_line;
	cache_pkg::way_mask_t ld_vold;
	cache_pkg::way_mask_t ld_vnew;

	logic wr_acc;
	logic wr_d1;
	logic wr_d2;
	logic wr_inv_r;
	logic [`ADR_W-1:0] wr_adr_r;
	logic [`LINE_BYTES-1:0] wr_sel_r;
	logic [`LINE_BYTES*8-1:0] wr_dat_r;
	cache_pkg::way_mask_t wr_vld;
	cache_pkg::way_mask_t wr_hit;
	cache_pkg::way_mask_t wr_hit_r;
	cache_pkg::cache_set_t wr_merge;

	// ========================================
	// reset sweep
	// ========================================
	always_ff @(posedge wclk) begin
		if (rst1) begin
			swp_cnt <= '0;
			sweeping <= 1'b0;
		end else begin
			sweeping <= !swp_cnt[`HIBIT-`LOBIT+1];
			if (!swp_cnt[`HIBIT-`LOBIT+1])
				swp_cnt <= swp_cnt + 1'b1;
		end
	end

	// sweeping lags the counter by one edge so the cleared set trails it
	assign swp_idx = swp_cnt[`HIBIT-`LOBIT:0] - 1'b1;

	// ========================================
	// load pipeline
	// ========================================
	always_ff @(posedge wclk) begin
		if (rst1) begin
			ld_d1 <= 1'b0;
			ld_d2 <= 1'b0;
			wr_d1 <= 1'b0;
			wr_d2 <= 1'b0;
			wr_ack <= 1'b0;
		end else begin
			ld_d1 <= ld.cyc;
			ld_d2 <= ld_d1;
			wr_d1 <= wr_acc;
			wr_d2 <= wr_d1;
			wr_ack <= wr_d2;
		end
	end

	always_ff @(posedge wclk) begin
		if (ld.cyc) begin
			ld_adr_r <= ld.adr;
			ld_dat_r <= ld.dat;
		end
	end

	always_comb begin
		ld_line.tag = ld_adr_r[`ADR_W-1:`TAGLOBIT];
		ld_line.modified = 1'b0;
		ld_line.data = ld_dat_r;
	end

	assign ld_vold = vbits[ld_adr_r[`HIBIT:`LOBIT]];

	// ========================================
	// write merge and invalidate
	// ========================================
	// a load anywhere in its three cycles holds the write off
	assign wr_acc = wr.cyc && !(wr_d1 || wr_d2 || wr_ack) && !(ld.cyc || ld_d1 || ld_d2);

	always_ff @(posedge wclk) begin
		if (wr_acc) begin
			wr_adr_r <= wr.adr;
			wr_sel_r <= wr.sel;
			wr_dat_r <= wr.dat;
			wr_inv_r <= wr.inv;
		end
	end

	assign own_rd_idx = ld.cyc ? ld.adr[`HIBIT:`LOBIT] : wr.adr[`HIBIT:`LOBIT];
	assign wr_vld = vbits[wr_adr_r[`HIBIT:`LOBIT]];

	always_comb begin
		wr_merge = own_rd_set;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			wr_hit[w] = wr_vld[w] && (own_rd_set[w].tag == wr_adr_r[`ADR_W-1:`TAGLOBIT]);
			if (wr_hit[w]) begin
				wr_merge[w].modified = 1'b1;
				for (int b = 0; b < `LINE_BYTES; b++) begin
					if (wr_sel_r[b])
						wr_merge[w].data[b*8 +: 8] = wr_dat_r[b*8 +: 8];
				end
			end
		end
	end

	// ========================================
	// RAM write port and valid bits
	// ========================================
	always_ff @(posedge wclk) begin
		if (rst1)
			ram_we <= 1'b0;
		else
			ram_we <= ld_d1 || (wr_d1 && (|wr_hit) && !wr_inv_r);
	end

	// new line enters way 0 and the old way 3 falls out
	always_ff @(posedge wclk) begin
		if (ld_d1) begin
			ram_idx <= ld_adr_r[`HIBIT:`LOBIT];
			ram_wset <= {own_rd_set[`CACHE_WAYS-2:0], ld_line};
			ld_vnew <= {ld_vold[`CACHE_WAYS-2:0], 1'b1};
		end else if (wr_d1) begin
			ram_idx <= wr_adr_r[`HIBIT:`LOBIT];
			ram_wset <= wr_merge;
			wr_hit_r <= wr_hit;
		end
	end

	always_ff @(posedge wclk) begin
		if (sweeping)
			vbits[swp_idx] <= '0;
		else if (ld_d2)
			vbits[ram_idx] <= ld_vnew;
		else if (wr_d2 && wr_inv_r)
			vbits[ram_idx] <= vbits[ram_idx] & ~wr_hit_r;
	end

	always_comb begin
		for (int p = 0; p < `NUM_RD_PORTS; p++)
			port_valid[p] = vbits[port_idx[p]];
	end

	// a load arriving behind an accepted write would shift a stale set
	a_wr_ld: assert property (@(posedge wclk) disable iff (rst1) wr_d2 |-> !ld_d1)
		else $error("write commit collides with a load capture");

endmodule

`default_nettype wire

//--- miss_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module miss_arbiter (
	input wire logic wclk,
	input wire logic rst1,
	input wire logic [`NUM_RD_PORTS-1:0] miss_stb,
	input wire logic [`TID_W-1:0] miss_tid [`NUM_RD_PORTS],
	input wire logic [`ADR_W-1:0] miss_adr [`NUM_RD_PORTS],
	output logic [`NUM_RD_PORTS-1:0] issued,
	output bus_pkg::miss_req_t miss
);

	logic [`NUM_RD_PORTS-1:0] pend;
	logic [`NUM_RD_PORTS-1:0] cand;
	logic [`NUM_RD_PORTS-1:0] grant;
	logic miss_cyc;
	logic [`TID_W-1:0] sel_tid;
	logic [`ADR_W-1:0] sel_adr;
	logic [`TID_W-1:0] miss_tid_r;
	logic [`ADR_W-1:0] miss_adr_r;

	// channel 0 wins, lowest set bit of the candidates
	assign cand = miss_stb & ~pend;
	assign grant = cand & (~cand + 1'b1);

	always_comb begin
		sel_tid = '0;
		sel_adr = '0;
		for (int i = 0; i < `NUM_RD_PORTS; i++) begin
			if (grant[i]) begin
				sel_tid = miss_tid[i];
				sel_adr = miss_adr[i];
			end
		end
	end

	// pend covers the cycle until the channel drops its strobe
	always_ff @(posedge wclk) begin
		if (rst1) begin
			pend <= '0;
			issued <= '0;
			miss_cyc <= 1'b0;
		end else begin
			pend <= (pend & miss_stb) | grant;
			issued <= grant;
			miss_cyc <= |grant;
		end
	end

	always_ff @(posedge wclk) begin
		if (|grant) begin
			miss_tid_r <= sel_tid;
			miss_adr_r <= sel_adr;
		end
	end

	assign miss = '{cyc: miss_cyc, tid: miss_tid_r, adr: miss_adr_r};

	a_one_issue: assert property (@(posedge wclk) disable iff (rst1) $onehot0(issued))
		else $error("more than one channel issued at once");

endmodule

`default_nettype wire

//--- mport_cache.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module mport_cache (
	input wire logic wclk,
	input wire logic rst1,
	input wire bus_pkg::rd_req_t rd_req [`NUM_RD_PORTS],
	output bus_pkg::rd_resp_t rd_resp [`NUM_RD_PORTS],
	input wire bus_pkg::wr_req_t wr_req,
	output logic wr_ack,
	input wire bus_pkg::ld_req_t ld_req,
	output bus_pkg::miss_req_t miss,
	output logic sweeping
);

	logic ram_we;
	logic [`HIBIT-`LOBIT:0] ram_idx;
	cache_pkg::cache_set_t ram_wset;

	// the last RAM copy belongs to the fill engine
	logic ram_rd_en [`NUM_RD_PORTS+1];
	logic [`HIBIT-`LOBIT:0] ram_rd_idx [`NUM_RD_PORTS+1];
	cache_pkg::cache_set_t ram_rd_set [`NUM_RD_PORTS+1];

	logic [`HIBIT-`LOBIT:0] port_idx [`NUM_RD_PORTS];
	cache_pkg::way_mask_t port_valid [`NUM_RD_PORTS];
	logic [`NUM_RD_PORTS-1:0] miss_stb;
	logic [`NUM_RD_PORTS-1:0] issued;
	logic [`TID_W-1:0] miss_tid [`NUM_RD_PORTS];
	logic [`ADR_W-1:0] miss_adr [`NUM_RD_PORTS];

	genvar g;

	// ========================================
	// set RAM copies, one per reader
	// ========================================
	for (g = 0; g < `NUM_RD_PORTS + 1; g++) begin : g_ram
		cache_set_ram u_ram (
			.wclk   (wclk),
			.we     (ram_we),
			.wr_idx (ram_idx),
			.wr_set (ram_wset),
			.rd_en  (ram_rd_en[g]),
			.rd_idx (ram_rd_idx[g]),
			.rd_set (ram_rd_set[g])
		);
	end

	// ========================================
	// read channels
	// ========================================
	for (g = 0; g < `NUM_RD_PORTS; g++) begin : g_port
		cache_read_port u_port (
			.wclk     (wclk),
			.rst1     (rst1),
			.req      (rd_req[g]),
			.resp     (rd_resp[g]),
			.rd_en    (ram_rd_en[g]),
			.rd_idx   (ram_rd_idx[g]),
			.rd_set   (ram_rd_set[g]),
			.valid    (port_valid[g]),
			.miss_stb (miss_stb[g]),
			.miss_tid (miss_tid[g]),
			.miss_adr (miss_adr[g]),
			.issued   (issued[g])
		);

		assign port_idx[g] = ram_rd_idx[g];
	end

	// the fill engine reads its set every cycle
	assign ram_rd_en[`NUM_RD_PORTS] = 1'b1;

	cache_fill_update u_fill (
		.wclk       (wclk),
		.rst1       (rst1),
		.ld         (ld_req),
		.wr         (wr_req),
		.wr_ack     (wr_ack),
		.sweeping   (sweeping),
		.ram_we     (ram_we),
		.ram_idx    (ram_idx),
		.ram_wset   (ram_wset),
		.own_rd_set (ram_rd_set[`NUM_RD_PORTS]),
		.own_rd_idx (ram_rd_idx[`NUM_RD_PORTS]),
		.port_idx   (port_idx),
		.port_valid (port_valid)
	);

	miss_arbiter u_arb (
		.wclk     (wclk),
		.rst1     (rst1),
		.miss_stb (miss_stb),
		.miss_tid (miss_tid),
		.miss_adr (miss_adr),
		.issued   (issued),
		.miss     (miss)
	);

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real period = 40.0
) (
	output logic clk
);

	// free running, starts low
	initial begin
		clk = 1'b0;
		forever #(period / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- tb_mport_cache.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module tb_mport_cache;

	logic wclk;
	logic rst1;
	bus_pkg::rd_req_t rd_req [`NUM_RD_PORTS];
	bus_pkg::rd_resp_t rd_resp [`NUM_RD_PORTS];
	bus_pkg::wr_req_t wr_req;
	logic wr_ack;
	bus_pkg::ld_req_t ld_req;
	bus_pkg::miss_req_t miss;
	logic sweeping;

	// reference model of the cache, way 0 holds the newest line
	logic [`ADR_W-`TAGLOBIT-1:0] m_tag [0:`CACHE_SETS-1][0:`CACHE_WAYS-1];
	logic [`LINE_BYTES*8-1:0] m_dat [0:`CACHE_SETS-1][0:`CACHE_WAYS-1];
	logic m_vld [0:`CACHE_SETS-1][0:`CACHE_WAYS-1];

	// what each channel may return next
	logic [`LINE_BYTES*8-1:0] exp_dat [`NUM_RD_PORTS];
	logic ack_open [`NUM_RD_PORTS];
	logic pending [`NUM_RD_PORTS];
	logic [`ADR_W-1:0] pend_adr [`NUM_RD_PORTS];
	int ack_cnt [`NUM_RD_PORTS];
	int ack_base [`NUM_RD_PORTS];
	int exp_acks [`NUM_RD_PORTS];

	// miss requests in the order they must leave the arbiter
	logic [`TID_W-1:0] exp_mtid [0:15];
	logic [`ADR_W-1:0] exp_madr [0:15];
	int exp_mcnt;
	int miss_seen;

	int data_errors;
	int miss_errors;
	int other_errors;

	tb_clock #(.period(40.0)) u_clock (.clk(wclk));

	mport_cache u_mport_cache (
		.wclk     (wclk),
		.rst1     (rst1),
		.rd_req   (rd_req),
		.rd_resp  (rd_resp),
		.wr_req   (wr_req),
		.wr_ack   (wr_ack),
		.ld_req   (ld_req),
		.miss     (miss),
		.sweeping (sweeping)
	);

	// ========================================
	// checkers
	// ========================================
	for (genvar c = 0; c < `NUM_RD_PORTS; c++) begin : g_chk
		a_rd_resp: assert property (@(posedge wclk) disable iff (rst1)
			rd_resp[c].ack |-> (ack_open[c] && rd_resp[c].dat == exp_dat[c]))
		else begin
			data_errors++;
			$display("mismatch at %0t: channel %0d ack without its line or with wrong data",
				$time, c);
		end
	end

	a_miss_req: assert property (@(posedge wclk) disable iff (rst1)
		miss.cyc |-> (miss_seen < exp_mcnt && miss.tid == exp_mtid[miss_seen]
			&& miss.adr == exp_madr[miss_seen]))
	else begin
		miss_errors++;
		$display("mismatch at %0t: miss request tid %h adr %h not expected", $time,
			miss.tid, miss.adr);
	end

	// the write request drops right after its ack, so a second ack cycle has no request
	a_wr_ack: assert property (@(posedge wclk) disable iff (rst1)
		wr_ack |-> $past(wr_req.cyc))
	else begin
		other_errors++;
		$display("mismatch at %0t: wr_ack without an open write or longer than one cycle",
			$time);
	end

	always @(posedge wclk) begin
		if (rst1) begin
			miss_seen <= 0;
			for (int c = 0; c < `NUM_RD_PORTS; c++)
				ack_cnt[c] <= 0;
		end else begin
			if (miss.cyc)
				miss_seen <= miss_seen + 1;
			for (int c = 0; c < `NUM_RD_PORTS; c++)
				if (rd_resp[c].ack)
					ack_cnt[c] <= ack_cnt[c] + 1;
		end
	end

	// ========================================
	// model helpers
	// ========================================
	function automatic logic [`ADR_W-1:0] line_adr(input int tag, input int set, input int off);
		return {tag[`ADR_W-`TAGLOBIT-1:0], set[`HIBIT-`LOBIT:0], off[`LOBIT-1:0]};
	endfunction

	// way that holds the line, or -1
	function automatic int find_way(input logic [`ADR_W-1:0] adr);
		logic [`HIBIT-`LOBIT:0] s;
		int way;
		s = adr[`HIBIT:`LOBIT];
		way = -1;
		for (int w = 0; w < `CACHE_WAYS; w++)
			if (m_vld[s][w] && m_tag[s][w] == adr[`ADR_W-1:`TAGLOBIT])
				way = w;
		return way;
	endfunction

	function automatic logic [`LINE_BYTES*8-1:0] rand_line();
		logic [`LINE_BYTES*8-1:0] v;
		for (int i = 0; i < `LINE_BYTES / 4; i++)
			v[i*32 +: 32] = $urandom;
		return v;
	endfunction

	// ========================================
	// stimulus tasks
	// ========================================
	task automatic step();
		@(posedge wclk);
		#1;
		for (int c = 0; c < `NUM_RD_PORTS; c++)
			rd_req[c].cyc = 1'b0;
		ld_req.cyc = 1'b0;
	endtask

	task automatic settle(input int cycles);
		for (int i = 0; i < cycles; i++)
			step();
	endtask

	// acks, miss requests and sweeping all start low
	task automatic check_reset_outputs();
		logic any_high;
		any_high = wr_ack || miss.cyc || sweeping;
		for (int c = 0; c < `NUM_RD_PORTS; c++)
			any_high = any_high || rd_resp[c].ack;
		assert (!any_high) else begin
			other_errors++;
			$display("mismatch at %0t: an ack, miss or sweeping output is high in reset",
				$time);
		end
	endtask

	task automatic start_read(input int ch, input int tid, input logic [`ADR_W-1:0] adr);
		int w;
		w = find_way(adr);
		rd_req[ch] = '{cyc: 1'b1, tid: tid[`TID_W-1:0], adr: adr};
		ack_base[ch] = ack_cnt[ch];
		pend_adr[ch] = adr;
		pending[ch] = 1'b1;
		if (w >= 0) begin
			exp_dat[ch] = m_dat[adr[`HIBIT:`LOBIT]][w];
			ack_open[ch] = 1'b1;
		end else begin
			// absent line, exactly one miss request follows
			ack_open[ch] = 1'b0;
			exp_mtid[exp_mcnt] = tid[`TID_W-1:0];
			exp_madr[exp_mcnt] = adr;
			exp_mcnt++;
		end
	endtask

	task automatic wait_ack(input int ch);
		int n;
		n = 0;
		while (ack_cnt[ch] == ack_base[ch] && n < 200) begin
			step();
			n++;
		end
		if (ack_cnt[ch] == ack_base[ch]) begin
			other_errors++;
			$display("timeout waiting for the read ack on channel %0d", ch);
		end
		exp_acks[ch]++;
		pending[ch] = 1'b0;
		ack_open[ch] = 1'b0;
	endtask

	task automatic wait_misses();
		int n;
		n = 0;
		while (miss_seen < exp_mcnt && n < 200) begin
			step();
			n++;
		end
		if (miss_seen < exp_mcnt) begin
			other_errors++;
			$display("timeout waiting for miss requests, %0d expected and %0d seen",
				exp_mcnt, miss_seen);
		end
	endtask

	task automatic check_counts();
		assert (miss_seen == exp_mcnt) else begin
			miss_errors++;
			$display("mismatch at %0t: %0d miss requests expected, %0d seen", $time,
				exp_mcnt, miss_seen);
		end
		for (int c = 0; c < `NUM_RD_PORTS; c++) begin
			assert (ack_cnt[c] == exp_acks[c]) else begin
				data_errors++;
				$display("mismatch at %0t: channel %0d gave %0d acks, %0d expected", $time,
					c, ack_cnt[c], exp_acks[c]);
			end
		end
	endtask

	// the new line enters way 0, the others move down and way 3 drops out
	task automatic load_line(input logic [`ADR_W-1:0] adr, input logic [`LINE_BYTES*8-1:0] dat);
		logic [`HIBIT-`LOBIT:0] s;
		s = adr[`HIBIT:`LOBIT];
		for (int w = `CACHE_WAYS - 1; w > 0; w--) begin
			m_tag[s][w] = m_tag[s][w-1];
			m_dat[s][w] = m_dat[s][w-1];
			m_vld[s][w] = m_vld[s][w-1];
		end
		m_tag[s][0] = adr[`ADR_W-1:`TAGLOBIT];
		m_dat[s][0] = dat;
		m_vld[s][0] = 1'b1;
		for (int c = 0; c < `NUM_RD_PORTS; c++) begin
			if (pending[c] && pend_adr[c][`ADR_W-1:`LOBIT] == adr[`ADR_W-1:`LOBIT]) begin
				exp_dat[c] = dat;
				ack_open[c] = 1'b1;
			end
		end
		ld_req = '{cyc: 1'b1, adr: adr, dat: dat};
		// loads need three quiet cycles between them
		settle(4);
	endtask

	// with no load in flight the ack comes three cycles after the request
	task automatic write_line(input logic [`ADR_W-1:0] adr, input logic inv,
			input logic [`LINE_BYTES-1:0] sel, input logic [`LINE_BYTES*8-1:0] dat);
		logic [`HIBIT-`LOBIT:0] s;
		int w;
		int n;
		s = adr[`HIBIT:`LOBIT];
		w = find_way(adr);
		n = 0;
		if (w >= 0 && inv)
			m_vld[s][w] = 1'b0;
		else if (w >= 0)
			for (int b = 0; b < `LINE_BYTES; b++)
				if (sel[b])
					m_dat[s][w][b*8 +: 8] = dat[b*8 +: 8];
		wr_req = '{cyc: 1'b1, inv: inv, adr: adr, sel: sel, dat: dat};
		do begin
			step();
			n++;
		end while (!wr_ack && n < 50);
		if (!wr_ack) begin
			other_errors++;
			$display("timeout waiting for the write ack");
		end else if (n != 3) begin
			other_errors++;
			$display("mismatch at %0t: write acked after %0d cycles, 3 expected", $time, n);
		end
		wr_req.cyc = 1'b0;
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		logic [`ADR_W-1:0] a_adr;
		logic [`ADR_W-1:0] c_adr;
		logic [`ADR_W-1:0] d_adr;
		int n;
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(32'h5dc7_12c2));
		rst1 = 1'b1;
		wr_req = '0;
		ld_req = '0;
		data_errors = 0;
		miss_errors = 0;
		other_errors = 0;
		exp_mcnt = 0;
		for (int c = 0; c < `NUM_RD_PORTS; c++) begin
			rd_req[c] = '0;
			pending[c] = 1'b0;
			ack_open[c] = 1'b0;
			ack_base[c] = 0;
			exp_acks[c] = 0;
		end
		for (int s = 0; s < `CACHE_SETS; s++)
			for (int w = 0; w < `CACHE_WAYS; w++)
				m_vld[s][w] = 1'b0;

		repeat (8) @(posedge wclk);
		#1;
		check_reset_outputs();
		rst1 = 1'b0;
		n = 0;
		while (!sweeping && n < 20) begin
			step();
			n++;
		end
		if (!sweeping) begin
			other_errors++;
			$display("timeout waiting for the reset sweep to start");
		end
		n = 0;
		while (sweeping && n < 2 * `CACHE_SETS) begin
			step();
			n++;
		end
		if (sweeping) begin
			other_errors++;
			$display("timeout waiting for the reset sweep to finish");
		end else if (n != `CACHE_SETS) begin
			other_errors++;
			$display("mismatch at %0t: reset sweep lasted %0d cycles, %0d expected", $time,
				n, `CACHE_SETS);
		end

		// cold miss, fill, then a hit on the same line
		a_adr = line_adr(32'h00a5, 3, 4);
		start_read(0, 32'h11, a_adr);
		step();
		wait_misses();
		settle(8);
		check_counts();
		load_line(a_adr, rand_line());
		wait_ack(0);
		start_read(0, 32'h12, a_adr);
		step();
		wait_ack(0);
		settle(4);
		check_counts();

		// byte merge on a write hit, and a write miss that changes nothing
		write_line(a_adr, 1'b0, $urandom, rand_line());
		start_read(1, 32'h21, a_adr);
		step();
		wait_ack(1);
		write_line(line_adr(32'h01f0, 3, 0), 1'b0, $urandom, rand_line());
		start_read(0, 32'h13, a_adr);
		step();
		wait_ack(0);
		settle(4);
		check_counts();

		// five lines into one set push the first one out
		for (int i = 0; i < 5; i++)
			load_line(line_adr(32'h100 + i, 20, 0), rand_line());
		for (int i = 1; i < 5; i++) begin
			start_read(i % 2, 32'h30 + i, line_adr(32'h100 + i, 20, 0));
			step();
			wait_ack(i % 2);
		end
		start_read(0, 32'h3f, line_adr(32'h100, 20, 0));
		step();
		wait_misses();
		settle(8);
		check_counts();
		load_line(line_adr(32'h100, 20, 0), rand_line());
		wait_ack(0);

		// invalidate, then the line has to be fetched again
		write_line(a_adr, 1'b1, '0, '0);
		start_read(1, 32'h41, a_adr);
		step();
		wait_misses();
		settle(8);
		check_counts();
		load_line(a_adr, rand_line());
		wait_ack(1);

		// both channels miss together, channel 0 goes out first
		c_adr = line_adr(32'h0777, 40, 8);
		d_adr = line_adr(32'h0888, 41, 16);
		start_read(0, 32'h51, c_adr);
		start_read(1, 32'h52, d_adr);
		step();
		wait_misses();
		settle(8);
		check_counts();
		load_line(c_adr, rand_line());
		load_line(d_adr, rand_line());
		wait_ack(0);
		wait_ack(1);
		settle(8);
		check_counts();

		$display("errors: data %0d, miss %0d, other %0d", data_errors, miss_errors,
			other_errors);
		if (data_errors == 0 && miss_errors == 0 && other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
bus_pkg.sv
cache_pkg.sv
cache_set_ram.sv
cache_read_port.sv
cache_fill_update.sv
miss_arbiter.sv
mport_cache.sv
tb_clock.sv
tb_mport_cache.sv

//--- Makefile
BIN = obj_dir/Vtb_mport_cache
SRCS = $(shell grep -v '^+' project.f) cache_consts.svh

.PHONY: all run clean

all: run

$(BIN): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mport_cache -f project.f

run: $(BIN)
	-./$(BIN) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
